// File: verification/soc_bus_stim.txt
// mask | host 0: we addr wdata be rdata err | host 1: we addr wdata be rdata err | chk val
// chk: 0 none, 1 gp_o, 2 timer_irq_o, 3 idle after reset, 4 host 0 rdata equals gp_i
0 0 00000000 00000000 0 00000000 0 0 00000000 00000000 0 00000000 0 3 0
1 1 00100000 AAAAAAAA F 00000000 0 0 00000000 00000000 0 00000000 0 0 0
2 0 00000000 00000000 0 00000000 0 1 00100000 11223344 3 00000000 0 0 0
2 0 00000000 00000000 0 00000000 0 1 00100008 55555555 F 00000000 0 0 0
1 1 00100008 12345678 C 00000000 0 0 00000000 00000000 0 00000000 0 0 0
3 0 00100000 00000000 0 AAAA3344 0 0 00100008 00000000 0 12345555 0 0 0
3 1 00100004 CAFEF00D F 00000000 0 0 00100000 00000000 0 AAAA3344 0 0 0
3 0 00100004 00000000 0 CAFEF00D 0 0 00100004 00000000 0 CAFEF00D 0 0 0
1 1 80000000 0000BEEF 3 00000000 0 0 00000000 00000000 0 00000000 0 1 BEEF
2 0 00000000 00000000 0 00000000 0 0 80000000 00000000 0 0000BEEF 0 0 0
1 1 80000000 00001200 2 00000000 0 0 00000000 00000000 0 00000000 0 1 12EF
1 0 80000004 00000000 0 00000000 0 0 00000000 00000000 0 00000000 0 4 0
1 1 80002004 00001000 F 00000000 0 0 00000000 00000000 0 00000000 0 0 0
2 0 00000000 00000000 0 00000000 0 0 80002004 00000000 0 00001000 0 0 0
1 1 80002004 FFFFFFFF F 00000000 0 0 00000000 00000000 0 00000000 0 2 0
1 1 80002004 00000000 F 00000000 0 0 00000000 00000000 0 00000000 0 2 1
3 1 40000000 DEADBEEF F 00000000 1 0 40000004 00000000 0 00000000 1 0 0
1 0 00100000 00000000 0 AAAA3344 0 0 00000000 00000000 0 00000000 0 0 0

// File: sim.f
rtl/soc_pkg.sv
rtl/bus_arbiter.sv
rtl/sram_device.sv
rtl/gpio_device.sv
rtl/timer_device.sv
rtl/soc_bus_top.sv
verification/bus_checker.sv
verification/tb_soc_bus.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run from the project root, then search the log for the pass message
rm -rf obj_dir build.log sim.log
verilator --binary --timing -j 0 --top-module tb_soc_bus -f sim.f -o tb_soc_bus \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_soc_bus > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verification/tb_soc_bus.sv
// Testbench for the bus subsystem; replays the stim file on both host ports and reports the result
`timescale 1ns/1ps

module tb_soc_bus;
  import soc_pkg::*;

  localparam int MAX_LINES    = 32;
  localparam int NR_FIELDS    = 15;
  localparam int RESET_CYCLES = 10;
  localparam int CHK_GPO      = 1;
  localparam int CHK_IRQ      = 2;
  localparam int CHK_GPI      = 4;

  logic                 clk_sys = 1'b0;
  logic                 rst_sys_n;
  bus_req_t             host_req [NR_HOSTS];
  bus_rsp_t             host_rsp [NR_HOSTS];
  logic [GPI_WIDTH-1:0] gpi;
  logic [GPO_WIDTH-1:0] gpo;
  logic                 timer_irq;
  logic                 line_done;
  int                   line_idx;
  int                   tests_run;
  int                   tests_failed;
  int                   errors;

  logic [31:0] stim [MAX_LINES*NR_FIELDS];
  int          n_lines = 0;
  int          cycle_limit = 200;
  int          cycles = 0;
  integer      seed = 32'h5310;

  always #5 clk_sys = ~clk_sys;

  soc_bus_top u_dut (
    .clk_sys_i  (clk_sys),
    .rst_sys_ni (rst_sys_n),
    .host_req_i (host_req),
    .host_rsp_o (host_rsp),
    .gp_i       (gpi),
    .gp_o       (gpo),
    .timer_irq_o(timer_irq)
  );

  bus_checker u_checker (
    .clk_sys_i     (clk_sys),
    .rst_sys_ni    (rst_sys_n),
    .host_req_i    (host_req),
    .host_rsp_i    (host_rsp),
    .gp_i          (gpi),
    .gp_o_i        (gpo),
    .timer_irq_i   (timer_irq),
    .line_done_i   (line_done),
    .line_idx_i    (line_idx),
    .tests_run_o   (tests_run),
    .tests_failed_o(tests_failed),
    .errors_o      (errors)
  );

  // Limit scales with the number of stim lines
  always @(posedge clk_sys) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  // Issue one stim line and wait for every response it expects
  task automatic run_line(input int idx);
    int                  base;
    int                  chk;
    logic [NR_HOSTS-1:0] mask;
    logic [NR_HOSTS-1:0] pend;
    logic [NR_HOSTS-1:0] wait_rv;
    base = idx * NR_FIELDS;
    mask = stim[base][NR_HOSTS-1:0];
    chk  = int'(stim[base+13]);
    @(posedge clk_sys);
    line_idx <= idx;
    if (chk == CHK_GPI) begin
      gpi <= GPI_WIDTH'($random(seed));
      // Let the input settle through the synchronizer
      repeat (3) @(posedge clk_sys);
    end
    for (int h = 0; h < NR_HOSTS; h++) begin
      if (mask[h]) begin
        host_req[h] <= '{req: 1'b1, we: stim[base+1+6*h][0], be: stim[base+4+6*h][3:0],
                         addr: stim[base+2+6*h], wdata: stim[base+3+6*h]};
      end
    end
    pend    = mask;
    wait_rv = mask;
    while (wait_rv != '0) begin
      @(negedge clk_sys);
      for (int h = 0; h < NR_HOSTS; h++) begin
        if (host_rsp[h].rvalid) begin
          wait_rv[h] = 1'b0;
        end
        if (pend[h] && host_rsp[h].gnt) begin
          pend[h] = 1'b0;
        end
      end
      @(posedge clk_sys);
      for (int h = 0; h < NR_HOSTS; h++) begin
        if (mask[h] && !pend[h]) begin
          host_req[h] <= '0;
        end
      end
    end
    // Pins lag the response by up to three cycles
    if (chk == CHK_GPO || chk == CHK_IRQ) begin
      repeat (3) @(posedge clk_sys);
    end
    line_done <= 1'b1;
    @(posedge clk_sys);
    line_done <= 1'b0;
  endtask

  initial begin
    for (int i = 0; i < MAX_LINES*NR_FIELDS; i++) begin
      stim[i] = '1;
    end
    $readmemh("verification/soc_bus_stim.txt", stim);
    while (n_lines < MAX_LINES && stim[n_lines*NR_FIELDS] != '1) begin
      n_lines++;
    end
    cycle_limit = 8 * n_lines + 200;
    for (int h = 0; h < NR_HOSTS; h++) begin
      host_req[h] <= '0;
    end
    gpi       <= '0;
    line_done <= 1'b0;
    line_idx  <= 0;
    rst_sys_n <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_sys);
    rst_sys_n <= 1'b1;
    for (int i = 0; i < n_lines; i++) begin
      run_line(i);
    end
    repeat (2) @(posedge clk_sys);
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0 && tests_run == n_lines) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: verification/bus_checker.sv
// Bus response checker; replays the expected results of the stim file against the DUT pins
`timescale 1ns/1ps

module bus_checker (
  input  logic                          clk_sys_i,
  input  logic                          rst_sys_ni,
  input  soc_pkg::bus_req_t             host_req_i [soc_pkg::NR_HOSTS],
  input  soc_pkg::bus_rsp_t             host_rsp_i [soc_pkg::NR_HOSTS],
  input  logic [soc_pkg::GPI_WIDTH-1:0] gp_i,
  input  logic [soc_pkg::GPO_WIDTH-1:0] gp_o_i,
  input  logic                          timer_irq_i,
  input  logic                          line_done_i,
  input  int                            line_idx_i,
  output int                            tests_run_o,
  output int                            tests_failed_o,
  output int                            errors_o
);
  import soc_pkg::*;

  localparam int MAX_LINES = 32;
  localparam int NR_FIELDS = 15;
  localparam int CHK_GPO   = 1;
  localparam int CHK_IRQ   = 2;
  localparam int CHK_IDLE  = 3;
  localparam int CHK_GPI   = 4;

  // One expected response
  // With gpi set the data is whatever gp_i holds
  typedef struct packed {
    logic  gpi;
    logic  err;
    word_t rdata;
  } exp_t;

  logic [31:0]         stim [MAX_LINES*NR_FIELDS];
  exp_t                exp_q [NR_HOSTS][$];
  logic [NR_HOSTS-1:0] gnt_q = '0;
  logic                line_bad = 1'b0;
  int                  n_run = 0;
  int                  n_failed = 0;
  int                  n_err = 0;

  assign tests_run_o    = n_run;
  assign tests_failed_o = n_failed;
  assign errors_o       = n_err;

  // Build the per-host response queues in stim order
  initial begin
    int   n;
    int   base;
    exp_t e;
    for (int i = 0; i < MAX_LINES*NR_FIELDS; i++) begin
      stim[i] = '1;
    end
    $readmemh("verification/soc_bus_stim.txt", stim);
    n = 0;
    while (n < MAX_LINES && stim[n*NR_FIELDS] != '1) begin
      base = n * NR_FIELDS;
      for (int h = 0; h < NR_HOSTS; h++) begin
        if (stim[base][h]) begin
          e.gpi   = (h == 0) && (stim[base+13] == CHK_GPI);
          e.err   = stim[base+6+6*h][0];
          e.rdata = stim[base+5+6*h];
          exp_q[h].push_back(e);
        end
      end
      n++;
    end
  end

  task automatic report_error(input string msg);
    $display("%s", msg);
    n_err++;
    line_bad = 1'b1;
  endtask

  task automatic check_word(input string name, input word_t got, input word_t want);
    if (got !== want) begin
      report_error($sformatf("mismatch %s: got %08h, expected %08h", name, got, want));
    end
  endtask

  // Response strobes and pins in their reset state
  task automatic check_idle();
    for (int h = 0; h < NR_HOSTS; h++) begin
      check_word($sformatf("host_rsp_o[%0d].gnt", h), word_t'(host_rsp_i[h].gnt), '0);
      check_word($sformatf("host_rsp_o[%0d].rvalid", h), word_t'(host_rsp_i[h].rvalid), '0);
      check_word($sformatf("host_rsp_o[%0d].err", h), word_t'(host_rsp_i[h].err), '0);
    end
    check_word("gp_o", word_t'(gp_o_i), '0);
    check_word("timer_irq_o", word_t'(timer_irq_i), '0);
  endtask

  // Pin checks of a finished line, then its verdict
  task automatic finish_line(input int idx);
    int    chk;
    word_t val;
    chk = int'(stim[idx*NR_FIELDS+13]);
    val = stim[idx*NR_FIELDS+14];
    case (chk)
      CHK_GPO:  check_word("gp_o", word_t'(gp_o_i), val);
      CHK_IRQ:  check_word("timer_irq_o", word_t'(timer_irq_i), val);
      CHK_IDLE: check_idle();
      default: ;
    endcase
    n_run++;
    if (line_bad) begin
      n_failed++;
    end
    $display("test %0d: %s", idx, line_bad ? "fail" : "pass");
    line_bad = 1'b0;
  endtask

  // Sampled on the falling edge, half a cycle after the inputs change
  always @(negedge clk_sys_i) begin
    exp_t  e;
    word_t want;
    if (rst_sys_ni) begin
      if (host_req_i[0].req && !host_rsp_i[0].gnt) begin
        report_error("host 0 had to wait although it has priority");
      end
      for (int h = 0; h < NR_HOSTS; h++) begin
        if (host_rsp_i[h].gnt && !host_req_i[h].req) begin
          report_error($sformatf("host %0d was granted without a request", h));
        end
        for (int l = 0; l < h; l++) begin
          if (host_rsp_i[h].gnt && host_req_i[l].req) begin
            report_error($sformatf("host %0d was granted while host %0d was waiting", h, l));
          end
        end
        if (host_rsp_i[h].rvalid) begin
          if (!gnt_q[h]) begin
            report_error($sformatf("host %0d got rvalid without a grant the cycle before", h));
          end
          if (exp_q[h].size() == 0) begin
            report_error($sformatf("host %0d got a response that no test expected", h));
          end else begin
            e    = exp_q[h].pop_front();
            want = e.gpi ? word_t'(gp_i) : e.rdata;
            check_word($sformatf("host_rsp_o[%0d].rdata", h), host_rsp_i[h].rdata, want);
            check_word($sformatf("host_rsp_o[%0d].err", h), word_t'(host_rsp_i[h].err),
                       word_t'(e.err));
          end
        end
        gnt_q[h] = host_rsp_i[h].gnt;
      end
      if (line_done_i) begin
        finish_line(line_idx_i);
      end
    end else if (rst_sys_ni === 1'b0) begin
      check_idle();
    end
  end

endmodule

// File: rtl/soc_bus_top.sv
// Top level of the bus subsystem; two host ports feeding the arbiter, RAM, GPIO and timer
`timescale 1ns/1ps

module soc_bus_top (
  input  logic                          clk_sys_i,
  input  logic                          rst_sys_ni,
  input  soc_pkg::bus_req_t             host_req_i [soc_pkg::NR_HOSTS],
  output soc_pkg::bus_rsp_t             host_rsp_o [soc_pkg::NR_HOSTS],
  input  logic [soc_pkg::GPI_WIDTH-1:0] gp_i,
  output logic [soc_pkg::GPO_WIDTH-1:0] gp_o,
  output logic                          timer_irq_o
);
  import soc_pkg::*;

  // Arbiter to device requests
  dev_req_t ram_req;
  dev_req_t gpio_req;
  dev_req_t timer_req;

  // Registered device read data
  word_t    ram_rdata;
  word_t    gpio_rdata;
  word_t    timer_rdata;

  bus_arbiter u_bus_arbiter (
    .clk_sys_i    (clk_sys_i),
    .rst_sys_ni   (rst_sys_ni),
    .host_req_i   (host_req_i),
    .host_rsp_o   (host_rsp_o),
    .ram_req_o    (ram_req),
    .gpio_req_o   (gpio_req),
    .timer_req_o  (timer_req),
    .ram_rdata_i  (ram_rdata),
    .gpio_rdata_i (gpio_rdata),
    .timer_rdata_i(timer_rdata)
  );

  sram_device u_sram (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .dev_req_i (ram_req),
    .rdata_o   (ram_rdata)
  );

  gpio_device u_gpio (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .dev_req_i (gpio_req),
    .gp_i      (gp_i),
    .gp_o      (gp_o),
    .rdata_o   (gpio_rdata)
  );

  timer_device u_timer (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .dev_req_i  (timer_req),
    .timer_irq_o(timer_irq_o),
    .rdata_o    (timer_rdata)
  );

endmodule

// File: rtl/timer_device.sv
// Machine timer device; free-running mtime, mtimecmp compare and registered interrupt
`timescale 1ns/1ps

module timer_device (
  input  logic              clk_sys_i,
  input  logic              rst_sys_ni,
  input  soc_pkg::dev_req_t dev_req_i,
  output logic              timer_irq_o,
  output soc_pkg::word_t    rdata_o
);
  import soc_pkg::*;

  word_t mtime_q;
  word_t mtimecmp_q;
  word_t rdata_q;
  logic  irq_q;
  logic  wr_mtime;
  logic  wr_mtimecmp;

  // Register select by word offset
  assign wr_mtime    = dev_req_i.req && dev_req_i.we && (dev_req_i.addr == addr_t'(0));
  assign wr_mtimecmp = dev_req_i.req && dev_req_i.we && (dev_req_i.addr == addr_t'(1));

  // A write overrides the increment for that cycle
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q <= '0;
    end else if (wr_mtime) begin
      mtime_q <= be_merge(mtime_q, dev_req_i.wdata, dev_req_i.be);
    end else begin
      mtime_q <= mtime_q + word_t'(1);
    end
  end

  // All ones at reset keeps the interrupt quiet
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtimecmp_q <= '1;
    end else if (wr_mtimecmp) begin
      mtimecmp_q <= be_merge(mtimecmp_q, dev_req_i.wdata, dev_req_i.be);
    end
  end

  // Compare result lands one cycle later
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rdata_q <= '0;
    end else if (dev_req_i.req) begin
      if (dev_req_i.we) begin
        rdata_q <= '0;
      end else begin
        case (dev_req_i.addr)
          addr_t'(0): rdata_q <= mtime_q;
          addr_t'(1): rdata_q <= mtimecmp_q;
          default:    rdata_q <= '0;
        endcase
      end
    end
  end

  assign timer_irq_o = irq_q;
  assign rdata_o     = rdata_q;

endmodule

// File: rtl/gpio_device.sv
// GPIO device; output register at word 0, synchronized input port at word 1
`timescale 1ns/1ps

module gpio_device (
  input  logic                          clk_sys_i,
  input  logic                          rst_sys_ni,
  input  soc_pkg::dev_req_t             dev_req_i,
  input  logic [soc_pkg::GPI_WIDTH-1:0] gp_i,
  output logic [soc_pkg::GPO_WIDTH-1:0] gp_o,
  output soc_pkg::word_t                rdata_o
);
  import soc_pkg::*;

  logic [GPO_WIDTH-1:0] gpo_q;
  logic [GPI_WIDTH-1:0] gpi_meta_q;
  logic [GPI_WIDTH-1:0] gpi_sync_q;
  word_t                rdata_q;
  logic                 wr_gpo;

  assign wr_gpo = dev_req_i.req && dev_req_i.we && (dev_req_i.addr == addr_t'(0));

  // Two-flop synchronizer for the asynchronous inputs
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpo_q   <= '0;
      rdata_q <= '0;
    end else begin
      if (wr_gpo) begin
        gpo_q <= GPO_WIDTH'(be_merge(word_t'(gpo_q), dev_req_i.wdata, dev_req_i.be));
      end
      if (dev_req_i.req) begin
        if (dev_req_i.we) begin
          rdata_q <= '0;
        end else begin
          case (dev_req_i.addr)
            addr_t'(0): rdata_q <= word_t'(gpo_q);
            addr_t'(1): rdata_q <= word_t'(gpi_sync_q);
            default:    rdata_q <= '0;
          endcase
        end
      end
    end
  end

  assign gp_o    = gpo_q;
  assign rdata_o = rdata_q;

endmodule

// File: rtl/sram_device.sv
// Single-port word RAM on the shared bus; byte-enable writes, registered read data
`timescale 1ns/1ps

module sram_device (
  input  logic              clk_sys_i,
  input  logic              rst_sys_ni,
  input  soc_pkg::dev_req_t dev_req_i,
  output soc_pkg::word_t    rdata_o
);
  import soc_pkg::*;

  localparam int unsigned IDX_W = $clog2(RAM_WORDS);

  word_t             mem [RAM_WORDS];
  logic [IDX_W-1:0]  idx;
  word_t             rdata_q;

  // Window is already reduced to a word offset by the arbiter
  assign idx = dev_req_i.addr[IDX_W-1:0];

  always_ff @(posedge clk_sys_i) begin
    if (dev_req_i.req && dev_req_i.we) begin
      mem[idx] <= be_merge(mem[idx], dev_req_i.wdata, dev_req_i.be);
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rdata_q <= '0;
    end else if (dev_req_i.req) begin
      if (dev_req_i.we) begin
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: rtl/bus_arbiter.sv
// Shared bus arbiter; picks one host per cycle by fixed priority, decodes and routes responses
`timescale 1ns/1ps

module bus_arbiter (
  input  logic              clk_sys_i,
  input  logic              rst_sys_ni,
  input  soc_pkg::bus_req_t host_req_i [soc_pkg::NR_HOSTS],
  output soc_pkg::bus_rsp_t host_rsp_o [soc_pkg::NR_HOSTS],
  output soc_pkg::dev_req_t ram_req_o,
  output soc_pkg::dev_req_t gpio_req_o,
  output soc_pkg::dev_req_t timer_req_o,
  input  soc_pkg::word_t    ram_rdata_i,
  input  soc_pkg::word_t    gpio_rdata_i,
  input  soc_pkg::word_t    timer_rdata_i
);
  import soc_pkg::*;

  logic                win_valid;
  host_idx_t           win_idx;
  bus_req_t            win_req;
  dev_e                win_dev;

  logic                rsp_valid_q;
  host_idx_t           rsp_host_q;
  dev_e                rsp_dev_q;
  word_t               rsp_rdata;
  logic [NR_HOSTS-1:0] rsp_sel;

  function automatic dev_req_t dev_fanout(bus_req_t req, logic sel, addr_t mask);
    dev_req_t d;
    d.req   = sel;
    d.we    = req.we;
    d.be    = req.be;
    d.addr  = (req.addr & ~mask) >> 2;
    d.wdata = req.wdata;
    return d;
  endfunction

  // Lowest index wins, so host 0 always has priority
  always_comb begin
    win_valid = 1'b0;
    win_idx   = '0;
    for (int i = NR_HOSTS - 1; i >= 0; i--) begin
      if (host_req_i[i].req) begin
        win_valid = 1'b1;
        win_idx   = host_idx_t'(i);
      end
    end
    win_req = host_req_i[win_idx];
  end

  always_comb begin
    if ((win_req.addr & RAM_MASK) == RAM_START) begin
      win_dev = DEV_RAM;
    end else if ((win_req.addr & GPIO_MASK) == GPIO_START) begin
      win_dev = DEV_GPIO;
    end else if ((win_req.addr & TIMER_MASK) == TIMER_START) begin
      win_dev = DEV_TIMER;
    end else begin
      win_dev = DEV_NONE;
    end
  end

  // Unmapped accesses reach no device
  assign ram_req_o   = dev_fanout(win_req, win_valid && (win_dev == DEV_RAM), RAM_MASK);
  assign gpio_req_o  = dev_fanout(win_req, win_valid && (win_dev == DEV_GPIO), GPIO_MASK);
  assign timer_req_o = dev_fanout(win_req, win_valid && (win_dev == DEV_TIMER), TIMER_MASK);

  // Remember who owns the response due next cycle
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rsp_valid_q <= 1'b0;
      rsp_host_q  <= '0;
      rsp_dev_q   <= DEV_NONE;
    end else begin
      rsp_valid_q <= win_valid;
      if (win_valid) begin
        rsp_host_q <= win_idx;
        rsp_dev_q  <= win_dev;
      end
    end
  end

  always_comb begin
    case (rsp_dev_q)
      DEV_RAM:   rsp_rdata = ram_rdata_i;
      DEV_GPIO:  rsp_rdata = gpio_rdata_i;
      DEV_TIMER: rsp_rdata = timer_rdata_i;
      default:   rsp_rdata = '0;
    endcase
  end

  always_comb begin
    for (int i = 0; i < NR_HOSTS; i++) begin
      rsp_sel[i]           = rsp_valid_q && (rsp_host_q == host_idx_t'(i));
      host_rsp_o[i].gnt    = win_valid && (win_idx == host_idx_t'(i));
      host_rsp_o[i].rvalid = rsp_sel[i];
      host_rsp_o[i].rdata  = rsp_sel[i] ? rsp_rdata : '0;
      host_rsp_o[i].err    = rsp_sel[i] && (rsp_dev_q == DEV_NONE);
    end
  end

endmodule

// File: rtl/soc_pkg.sv
// Shared bus types, address map and helpers; imported by every module of the bus subsystem
package soc_pkg;

  // Bus widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  be_t;

  localparam int unsigned NR_HOSTS = 2;

  // Host index wide enough for every host port
  typedef logic [$clog2(NR_HOSTS)-1:0] host_idx_t;

  // Address map
  localparam addr_t RAM_START   = 32'h0010_0000;
  localparam addr_t RAM_SIZE    = 32'd1024;
  localparam addr_t RAM_MASK    = ~(RAM_SIZE - 32'd1);

  localparam addr_t GPIO_START  = 32'h8000_0000;
  localparam addr_t GPIO_SIZE   = 32'd4096;
  localparam addr_t GPIO_MASK   = ~(GPIO_SIZE - 32'd1);

  localparam addr_t TIMER_START = 32'h8000_2000;
  localparam addr_t TIMER_SIZE  = 32'd4096;
  localparam addr_t TIMER_MASK  = ~(TIMER_SIZE - 32'd1);

  // Device geometry
  localparam int unsigned RAM_WORDS = 256;
  localparam int unsigned GPI_WIDTH = 8;
  localparam int unsigned GPO_WIDTH = 16;

  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    word_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    word_t rdata;
    logic  err;
  } bus_rsp_t;

  // addr holds the word offset inside the device window
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    word_t wdata;
  } dev_req_t;

  typedef enum logic [1:0] {
    DEV_RAM,
    DEV_GPIO,
    DEV_TIMER,
    DEV_NONE
  } dev_e;

  // Replace the bytes of old_w selected by be with those of new_w
  function automatic word_t be_merge(word_t old_w, word_t new_w, be_t be);
    word_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

endpackage
